// File: flist.f
riscv_decode_pkg.sv
inst_decoder.sv
gpr_file.sv
csr_file.sv
decode_stage.sv
decode_top.sv
tb_decode_asserts.sv
tb_decode_top.sv

// File: run_sim.sh
#!/bin/bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_decode_top -f flist.f -o sim_decode \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_decode 2>&1 | tee sim.log
test -s sim.log || { echo "no simulation log"; exit 1; }
grep -q ">>> FAIL" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0

// File: tb_decode_top.sv
module tb_decode_top import riscv_decode_pkg::*; ;

    logic        clk;
    logic        rst_n_i;
    logic        in_valid_i;
    logic        in_ready_o;
    fetch_pkt_t  in_pkt_i;
    logic        out_valid_o;
    logic        out_ready_i;
    dec_bundle_t out_bundle_o;
    gpr_wr_t     gpr_wr_i;
    csr_wr_t     csr_wr_i;
    logic        ex_jump_flag_i;
    logic        mem_req_o;

    logic [XLEN-1:0] gpr_m [NUM_REGS]; // model of written registers
    logic [XLEN-1:0] csr_m [5];
    dec_bundle_t     expq [$];
    dec_bundle_t     exp_b;
    dec_bundle_t     last_out;
    dec_bundle_t     held;
    logic [31:0]     seed;
    logic [31:0]     rnd_r;
    logic [31:0]     pc;
    logic            rand_ready;
    int              cycles;

    decode_top DUT (.*);

    always #50 clk = ~clk;

    task automatic stop_run(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_bundle(string name, dec_bundle_t got, dec_bundle_t exp);
        if (got !== exp) stop_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) stop_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp) stop_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic int csr_slot(logic [11:0] a);
        case (a)
            CSR_MSTATUS:  return 0;
            CSR_MTVEC:    return 1;
            CSR_MEPC:     return 2;
            CSR_MCAUSE:   return 3;
            CSR_MSCRATCH: return 4;
            default:      return -1;
        endcase
    endfunction

    function automatic logic [31:0] enc(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // reference decode from the instruction set rules
    function automatic dec_bundle_t ref_bundle(logic [31:0] inst, logic [31:0] addr);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        r1;
        logic        r2;
        logic        wr;
        logic        keep;
        logic        csr;
        logic        mem;
        int          slot;
        dec_bundle_t b;
        f3 = inst[14:12];
        f7 = inst[31:25];
        {r1, r2, wr, keep, csr, mem} = 6'b0;
        case (inst[6:0])
            7'h13: {r1, wr} = 2'b11;
            7'h33: begin
                if (f7 == 7'h00 || f7 == 7'h20) {r1, r2, wr} = 3'b111;
                else if (f7 == 7'h01) {r1, r2, wr, keep} = {3'b110 | {2'b0, ~f3[2]}, 1'b1};
            end
            7'h03: if (f3 != 3'd3 && f3 < 3'd6) {r1, wr, mem} = 3'b111;
            7'h23: if (f3 < 3'd3) {r1, r2, mem} = 3'b111;
            7'h63: if (f3 != 3'd2 && f3 != 3'd3) {r1, r2} = 2'b11;
            7'h6f, 7'h37, 7'h17: wr = 1'b1;
            7'h67: {r1, wr} = 2'b11;
            7'h73: if (f3 != 3'd0 && f3 != 3'd4) {r1, wr, csr} = {~f3[2], 2'b11};
            default: ;
        endcase
        slot = csr_slot(inst[31:20]);
        b = '0;
        b.inst      = inst;
        b.inst_addr = addr;
        b.rs1_data  = r1 ? gpr_m[inst[19:15]] : '0;
        b.rs2_data  = r2 ? gpr_m[inst[24:20]] : '0;
        b.csr_data  = (csr && slot >= 0) ? csr_m[slot] : '0;
        b.reg_we    = wr;
        b.rd        = (wr || keep) ? inst[11:7] : '0;
        b.csr_we    = csr;
        b.csr_addr  = csr ? inst[31:20] : '0;
        b.mem_req   = mem;
        return b;
    endfunction

    task automatic write_gpr(logic [4:0] idx, logic [31:0] data);
        @(negedge clk);
        gpr_wr_i = '{we: 1'b1, addr: idx, data: data};
        if (idx != 5'd0) gpr_m[idx] = data;
        @(negedge clk);
        gpr_wr_i.we = 1'b0;
    endtask

    task automatic write_csr(logic [11:0] a, logic [31:0] data);
        @(negedge clk);
        csr_wr_i = '{we: 1'b1, addr: a, data: data};
        if (csr_slot(a) >= 0) csr_m[csr_slot(a)] = data;
        @(negedge clk);
        csr_wr_i.we = 1'b0;
    endtask

    task automatic offer_inst(logic [31:0] inst);
        in_valid_i = 1'b1;
        in_pkt_i   = '{inst: inst, inst_addr: pc};
        expq.push_back(ref_bundle(inst, pc));
        pc = pc + 32'd4;
    endtask

    task automatic send(logic [31:0] inst);
        @(negedge clk);
        offer_inst(inst);
        do @(posedge clk); while (!in_ready_o);
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid_i = 1'b0;
        while (expq.size() != 0) @(posedge clk);
    endtask

    function automatic logic [31:0] rand_inst();
        logic [31:0] r;
        r = lcg_next();
        case (r[18:16] % 3'd6)
            3'd0: return enc(r[26] ? 7'h20 : 7'h00, r[4:0], r[9:5], 3'd0, r[14:10], 7'h33);
            3'd1: return enc(r[6:0], r[4:0], r[9:5], 3'd0, r[14:10], 7'h13);
            3'd2: return enc(7'h00, 5'd8, r[9:5], 3'd2, r[14:10], 7'h03);
            3'd3: return enc(7'h00, r[4:0], r[9:5], 3'd2, 5'd0, 7'h23);
            3'd4: return enc(7'h00, r[4:0], r[9:5], 3'd1, 5'd4, 7'h63);
            default: return {12'h340 + {9'd0, r[2:0]}, r[9:5], 3'd2, r[14:10], 7'h73};
        endcase
    endfunction

    task automatic test_reset();
        check_bit("in_ready_o", in_ready_o, 1'b1);
        check_bit("out_valid_o", out_valid_o, 1'b0);
        check_bit("mem_req_o", mem_req_o, 1'b0);
        send(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));
        drain();
        check_word("rs1_data", last_out.rs1_data, 32'h0);
        check_word("rs2_data", last_out.rs2_data, 32'h0);
    endtask

    task automatic test_integer();
        for (int i = 31; i >= 0; i--) write_gpr(5'(i), lcg_next());
        send(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));   // add
        send(enc(7'h20, 5'd0, 5'd5, 3'd0, 5'd6, 7'h33));   // sub with x0
        send(enc(7'h00, 5'd7, 5'd8, 3'd2, 5'd9, 7'h33));   // slt
        send(enc(7'h00, 5'd10, 5'd11, 3'd1, 5'd12, 7'h33));
        send(enc(7'h00, 5'd13, 5'd14, 3'd5, 5'd15, 7'h33));
        send(enc(7'h20, 5'd16, 5'd17, 3'd5, 5'd18, 7'h33));
        send(enc(7'h00, 5'd19, 5'd20, 3'd7, 5'd21, 7'h33));
        send(enc(7'h12, 5'd5, 5'd22, 3'd0, 5'd23, 7'h13)); // addi
        send(enc(7'h24, 5'd6, 5'd7, 3'd5, 5'd24, 7'h37));  // lui
        send(enc(7'h11, 5'd1, 5'd2, 3'd3, 5'd25, 7'h17));  // auipc
        send(enc(7'h05, 5'd3, 5'd4, 3'd0, 5'd1, 7'h6f));   // jal
        send(enc(7'h33, 5'd3, 5'd4, 3'd0, 5'd1, 7'h7f));   // not an opcode
        drain();
    endtask

    task automatic test_muldiv();
        send(enc(7'h01, 5'd2, 5'd3, 3'd0, 5'd4, 7'h33));
        send(enc(7'h01, 5'd5, 5'd6, 3'd1, 5'd7, 7'h33));
        send(enc(7'h01, 5'd8, 5'd9, 3'd4, 5'd10, 7'h33)); // div keeps rd
        send(enc(7'h01, 5'd11, 5'd12, 3'd7, 5'd13, 7'h33));
        send(enc(7'h11, 5'd14, 5'd15, 3'd0, 5'd16, 7'h33));
        drain();
    endtask

    task automatic test_mem_gating();
        @(negedge clk);
        out_ready_i = 1'b0;
        send(enc(7'h00, 5'd4, 5'd3, 3'd2, 5'd8, 7'h03));   // lw
        @(negedge clk);
        in_valid_i = 1'b0;
        check_bit("out_valid_o", out_valid_o, 1'b1);
        check_bit("mem_req_o", mem_req_o, 1'b1);
        ex_jump_flag_i = 1'b1;
        @(negedge clk);
        check_bit("mem_req_o", mem_req_o, 1'b0);
        ex_jump_flag_i = 1'b0;
        out_ready_i    = 1'b1;
        send(enc(7'h02, 5'd9, 5'd10, 3'd2, 5'd3, 7'h23));  // sw
        send(enc(7'h00, 5'd11, 5'd12, 3'd0, 5'd6, 7'h63)); // beq
        drain();
    endtask

    task automatic test_csr();
        write_csr(CSR_MSCRATCH, lcg_next());
        write_csr(CSR_MTVEC, lcg_next());
        send({CSR_MSCRATCH, 5'd4, 3'd1, 5'd9, 7'h73});
        send({CSR_MTVEC, 5'd5, 3'd2, 5'd10, 7'h73});
        send({CSR_MSTATUS, 5'd17, 3'd5, 5'd11, 7'h73}); // immediate form
        send({12'h7c0, 5'd6, 3'd2, 5'd12, 7'h73});
        drain();
        check_word("csr_data", last_out.csr_data, 32'h0);
    endtask

    task automatic test_backpressure();
        @(negedge clk);
        out_ready_i = 1'b0;
        send(enc(7'h00, 5'd2, 5'd1, 3'd4, 5'd3, 7'h33));
        @(negedge clk);
        offer_inst(enc(7'h00, 5'd5, 5'd6, 3'd6, 5'd7, 7'h33)); // waits behind the held one
        check_bit("in_ready_o", in_ready_o, 1'b0);
        held = out_bundle_o;
        repeat (3) begin
            @(negedge clk);
            check_bit("out_valid_o", out_valid_o, 1'b1);
            check_bit("in_ready_o", in_ready_o, 1'b0);
            check_bundle("out_bundle_o", out_bundle_o, held);
        end
        out_ready_i = 1'b1;
        drain();
        rand_ready = 1'b1;
        repeat (20) send(rand_inst());
        drain();
        rand_ready = 1'b0;
        @(negedge clk);
        out_ready_i = 1'b1;
    endtask

    always @(negedge clk) begin
        if (rand_ready) begin
            rnd_r = lcg_next();
            out_ready_i = rnd_r[20];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            stop_run("timeout: the tests did not finish within 2000 cycles");
        end else if (rst_n_i && out_valid_o && out_ready_i) begin
            if (expq.size() == 0) begin
                stop_run("a bundle came out with no instruction sent");
            end else begin
                exp_b = expq.pop_front();
                check_bundle("out_bundle_o", out_bundle_o, exp_b);
                last_out = out_bundle_o;
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst_n_i = 1'b0;
        in_valid_i = 1'b0;
        in_pkt_i = '0;
        out_ready_i = 1'b1;
        gpr_wr_i = '0;
        csr_wr_i = '0;
        ex_jump_flag_i = 1'b0;
        rand_ready = 1'b0;
        seed = 32'd94200;
        pc = 32'h0000_1000;
        cycles = 0;
        for (int i = 0; i < NUM_REGS; i++) gpr_m[i] = '0;
        for (int i = 0; i < 5; i++) csr_m[i] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        test_reset();
        test_integer();
        test_muldiv();
        test_mem_gating();
        test_csr();
        test_backpressure();
        if (expq.size() != 0) begin
            stop_run("instructions were sent but never came out");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: tb_decode_asserts.sv
module decode_asserts import riscv_decode_pkg::*; (
    input logic        clk,
    input logic        rst_n_i,
    input logic        in_valid_i,
    input logic        in_ready_o,
    input logic        out_valid_o,
    input logic        out_ready_i,
    input dec_bundle_t out_bundle_o,
    input logic        ex_jump_flag_i,
    input logic        mem_req_o
);

    // held bundle must not move while execute stalls
    hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_bundle_o))
        else $error("bundle changed under back-pressure");

    // register full when a packet came in or a stalled bundle stayed
    ready_rule: assert property (@(posedge clk) disable iff (!rst_n_i)
        in_ready_o == (out_ready_i || !($past(in_valid_i && in_ready_o)
                                        || $past(out_valid_o && !out_ready_i))))
        else $error("in_ready_o does not match the output register occupancy");

    // only a held load or store reaches the bus
    no_req_on_jump: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_o |-> out_valid_o && !ex_jump_flag_i
                      && (out_bundle_o.inst[6:0] == OP_LOAD
                          || out_bundle_o.inst[6:0] == OP_STORE))
        else $error("memory request without a held load or store, or during a jump");

endmodule

bind decode_stage decode_asserts u_decode_asserts (.*);

// File: decode_top.sv
module decode_top import riscv_decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,

    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  fetch_pkt_t  in_pkt_i,

    output logic        out_valid_o,
    input  logic        out_ready_i,
    output dec_bundle_t out_bundle_o,

    // writeback ports
    input  gpr_wr_t     gpr_wr_i,
    input  csr_wr_t     csr_wr_i,

    input  logic        ex_jump_flag_i,
    output logic        mem_req_o
);

    dec_ctrl_t       ctrl;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] csr_data;

    inst_decoder u_inst_decoder (
        .inst_i (in_pkt_i.inst),
        .ctrl_o (ctrl)
    );

    gpr_file u_gpr_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_addr_i  (ctrl.raddr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (gpr_wr_i)
    );

    csr_file u_csr_file (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (ctrl.csr_addr),
        .rdata_o (csr_data),
        .wr_i    (csr_wr_i)
    );

    decode_stage u_decode_stage (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .in_pkt_i       (in_pkt_i),
        .ctrl_i         (ctrl),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .csr_data_i     (csr_data),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .out_bundle_o   (out_bundle_o),
        .ex_jump_flag_i (ex_jump_flag_i),
        .mem_req_o      (mem_req_o)
    );

endmodule

// File: decode_stage.sv
module decode_stage import riscv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,

    // from fetch
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  fetch_pkt_t      in_pkt_i,

    // decoder and storage, same cycle
    input  dec_ctrl_t       ctrl_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic [XLEN-1:0] csr_data_i,

    // to execute
    output logic            out_valid_o,
    input  logic            out_ready_i,
    output dec_bundle_t     out_bundle_o,
    input  logic            ex_jump_flag_i,
    output logic            mem_req_o
);

    logic        valid_q;
    dec_bundle_t bundle_q;
    logic        accept;

    assign in_ready_o = ~valid_q | out_ready_i; // empty or draining
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bundle_q.inst      <= in_pkt_i.inst;
            bundle_q.inst_addr <= in_pkt_i.inst_addr;
            bundle_q.rs1_data  <= rs1_data_i;
            bundle_q.rs2_data  <= rs2_data_i;
            bundle_q.csr_data  <= csr_data_i;
            bundle_q.reg_we    <= ctrl_i.reg_we;
            bundle_q.rd        <= ctrl_i.rd;
            bundle_q.csr_we    <= ctrl_i.csr_we;
            bundle_q.csr_addr  <= ctrl_i.csr_addr;
            bundle_q.mem_req   <= ctrl_i.mem_req;
        end
    end

    assign out_valid_o  = valid_q;
    assign out_bundle_o = bundle_q;

    // hold off the bus while execute redirects
    assign mem_req_o = valid_q & bundle_q.mem_req & ~ex_jump_flag_i;

endmodule

// File: csr_file.sv
module csr_file import riscv_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [CSR_ADDR_W-1:0] raddr_i,
    output logic [XLEN-1:0]       rdata_o,
    input  csr_wr_t               wr_i
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mscratch;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (wr_i.we) begin
            case (wr_i.addr)
                CSR_MSTATUS:  mstatus  <= wr_i.data;
                CSR_MTVEC:    mtvec    <= wr_i.data;
                CSR_MEPC:     mepc     <= wr_i.data;
                CSR_MCAUSE:   mcause   <= wr_i.data;
                CSR_MSCRATCH: mscratch <= wr_i.data;
                default: ; // not implemented, write dropped
            endcase
        end
    end

    always_comb begin
        case (raddr_i)
            CSR_MSTATUS:  rdata_o = mstatus;
            CSR_MTVEC:    rdata_o = mtvec;
            CSR_MEPC:     rdata_o = mepc;
            CSR_MCAUSE:   rdata_o = mcause;
            CSR_MSCRATCH: rdata_o = mscratch;
            default:      rdata_o = '0;
        endcase
    end

endmodule

// File: gpr_file.sv
module gpr_file import riscv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  reg_rd_addr_t    rd_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  gpr_wr_t         wr_i
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // no write-through, a write shows up the cycle after
    always_comb begin
        if (rd_addr_i.rs1 == '0) begin
            rs1_data_o = '0;
        end else begin
            rs1_data_o = regs[rd_addr_i.rs1];
        end
        if (rd_addr_i.rs2 == '0) begin
            rs2_data_o = '0;
        end else begin
            rs2_data_o = regs[rd_addr_i.rs2];
        end
    end

endmodule

// File: inst_decoder.sv
module inst_decoder import riscv_decode_pkg::*; (
    input  logic [XLEN-1:0] inst_i,
    output dec_ctrl_t       ctrl_o
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    always_comb begin
        ctrl_o = '0; // unknown encodings fall through as all zero
        case (opcode)
            OP_IMM: begin // every funct3 is a valid ALU op
                ctrl_o.raddr.rs1 = rs1;
                ctrl_o.reg_we    = 1'b1;
                ctrl_o.rd        = rd;
            end
            OP_REG: begin
                if (funct7 == F7_BASE || funct7 == F7_ALT) begin
                    ctrl_o.raddr.rs1 = rs1;
                    ctrl_o.raddr.rs2 = rs2;
                    ctrl_o.reg_we    = 1'b1;
                    ctrl_o.rd        = rd;
                end else if (funct7 == F7_MULDIV) begin
                    ctrl_o.raddr.rs1 = rs1;
                    ctrl_o.raddr.rs2 = rs2;
                    ctrl_o.reg_we    = ~funct3[2]; // div/rem write back later
                    ctrl_o.rd        = rd;
                end
            end
            OP_LOAD: begin
                if (funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) begin
                    ctrl_o.raddr.rs1 = rs1;
                    ctrl_o.reg_we    = 1'b1;
                    ctrl_o.rd        = rd;
                    ctrl_o.mem_req   = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 inside {F3_SB, F3_SH, F3_SW}) begin
                    ctrl_o.raddr.rs1 = rs1;
                    ctrl_o.raddr.rs2 = rs2;
                    ctrl_o.mem_req   = 1'b1;
                end
            end
            OP_BRANCH: begin
                if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
                    ctrl_o.raddr.rs1 = rs1;
                    ctrl_o.raddr.rs2 = rs2;
                end
            end
            OP_JAL, OP_LUI, OP_AUIPC: begin
                ctrl_o.reg_we = 1'b1;
                ctrl_o.rd     = rd;
            end
            OP_JALR: begin
                ctrl_o.raddr.rs1 = rs1;
                ctrl_o.reg_we    = 1'b1;
                ctrl_o.rd        = rd;
            end
            OP_SYSTEM_CSR: begin
                case (funct3)
                    F3_CSRRW, F3_CSRRS, F3_CSRRC: begin
                        ctrl_o.raddr.rs1 = rs1;
                        ctrl_o.reg_we    = 1'b1;
                        ctrl_o.rd        = rd;
                        ctrl_o.csr_addr  = inst_i[31:20];
                        ctrl_o.csr_we    = 1'b1;
                    end
                    F3_CSRRWI, F3_CSRRSI, F3_CSRRCI: begin
                        // rs1 field is the immediate here, nothing to read
                        ctrl_o.reg_we   = 1'b1;
                        ctrl_o.rd       = rd;
                        ctrl_o.csr_addr = inst_i[31:20];
                        ctrl_o.csr_we   = 1'b1;
                    end
                    default: ctrl_o = '0; // ecall/ebreak and reserved
                endcase
            end
            OP_FENCE, OP_NOP_CODE: ctrl_o = '0;
            default: ctrl_o = '0;
        endcase
    end

endmodule

// File: riscv_decode_pkg.sv
package riscv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int CSR_ADDR_W = 12;

    // machine CSRs kept by the stage
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;

    typedef enum logic [6:0] {
        OP_IMM        = 7'b0010011,
        OP_REG        = 7'b0110011, // R-type and M-extension
        OP_LOAD       = 7'b0000011,
        OP_STORE      = 7'b0100011,
        OP_BRANCH     = 7'b1100011,
        OP_JAL        = 7'b1101111,
        OP_JALR       = 7'b1100111,
        OP_LUI        = 7'b0110111,
        OP_AUIPC      = 7'b0010111,
        OP_FENCE      = 7'b0001111,
        OP_SYSTEM_CSR = 7'b1110011,
        OP_NOP_CODE   = 7'b0000001  // core's own bubble encoding
    } opcode_e;

    typedef enum logic [6:0] {
        F7_BASE   = 7'b0000000,
        F7_ALT    = 7'b0100000,
        F7_MULDIV = 7'b0000001
    } funct7_e;

    typedef enum logic [2:0] {
        F3_CSRRW  = 3'b001,
        F3_CSRRS  = 3'b010,
        F3_CSRRC  = 3'b011,
        F3_CSRRWI = 3'b101,
        F3_CSRRSI = 3'b110,
        F3_CSRRCI = 3'b111
    } csr_funct3_e;

    // memory and branch widths
    localparam logic [2:0] F3_LB   = 3'b000;
    localparam logic [2:0] F3_LH   = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_LHU  = 3'b101;
    localparam logic [2:0] F3_SB   = 3'b000;
    localparam logic [2:0] F3_SH   = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] inst_addr;
    } fetch_pkt_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
    } reg_rd_addr_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } gpr_wr_t;

    typedef struct packed {
        logic                  we;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } csr_wr_t;

    typedef struct packed {
        reg_rd_addr_t          raddr;
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] rd;
        logic [CSR_ADDR_W-1:0] csr_addr;
        logic                  csr_we;
        logic                  mem_req;
    } dec_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       inst_addr;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       csr_data;
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] rd;
        logic                  csr_we;
        logic [CSR_ADDR_W-1:0] csr_addr;
        logic                  mem_req;
    } dec_bundle_t;

endpackage
